// ==== src/rnn_num_pkg.sv ====
`default_nettype none

// fixed-point formats for the recurrent cell datapath
package rnn_num_pkg;

    localparam int WORD_W    = 16; // storage word width
    localparam int ACC_W     = 32; // accumulator width
    localparam int FRAC_BITS = 8;  // fractional bits of a stored word

    // weights, embeddings and hidden values, q8.8
    typedef logic signed [WORD_W-1:0] word_t;

    // products and running sums, q16.16
    typedef logic signed [ACC_W-1:0] acc_t;

endpackage

`default_nettype wire

// ==== src/rnn_mem_pkg.sv ====
`default_nettype none

// tags that travel with every weight-memory read
package rnn_mem_pkg;

    // wide enough for a hidden size of 8
    localparam int OPERAND_IDX_W = 3;

    typedef logic [OPERAND_IDX_W-1:0] idx_t;

    // what a returning word is for
    typedef enum logic [2:0] {
        KIND_EMBED = 3'd0, // embedding element of the token
        KIND_W_HH  = 3'd1, // weight times old hidden value
        KIND_B_HH  = 3'd2, // hidden bias
        KIND_W_IH  = 3'd3, // weight times embedding value
        KIND_B_IH  = 3'd4  // input bias, closes the neuron
    } req_kind_t;

endpackage

`default_nettype wire

// ==== src/rnn_step_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module rnn_step_sequencer #(
    parameter int VOCAB_SIZE  = 76,
    parameter int EMBED_SIZE  = 4,
    parameter int HIDDEN_SIZE = 8,
    parameter int ADDR_W      = 9,
    localparam int TOKEN_W    = $clog2(VOCAB_SIZE) + 1
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     start,
    input  wire [TOKEN_W-1:0]       token,
    input  wire                     data_valid,
    input  wire rnn_mem_pkg::req_kind_t last_kind,
    input  wire rnn_mem_pkg::idx_t  last_neuron,
    output logic                    busy,
    output logic                    done,
    output logic                    commit,
    output logic                    rd_en,
    output logic [ADDR_W-1:0]       rd_addr,
    output rnn_mem_pkg::req_kind_t  rd_kind,
    output rnn_mem_pkg::idx_t       rd_operand,
    output rnn_mem_pkg::idx_t       rd_neuron
);

    // region bases of the weight memory
    localparam int W_IH_BASE = VOCAB_SIZE * EMBED_SIZE;
    localparam int W_HH_BASE = W_IH_BASE + HIDDEN_SIZE * EMBED_SIZE;
    localparam int B_IH_BASE = W_HH_BASE + HIDDEN_SIZE * HIDDEN_SIZE;
    localparam int B_HH_BASE = B_IH_BASE + HIDDEN_SIZE;

    localparam rnn_mem_pkg::idx_t LAST_EMB = rnn_mem_pkg::idx_t'(EMBED_SIZE - 1);
    localparam rnn_mem_pkg::idx_t LAST_HID = rnn_mem_pkg::idx_t'(HIDDEN_SIZE - 1);

    logic                   issuing; // reads still being issued
    rnn_mem_pkg::req_kind_t phase;
    rnn_mem_pkg::idx_t      neuron;
    rnn_mem_pkg::idx_t      operand;
    logic [TOKEN_W-1:0]     token_q;
    logic                   accept;
    logic                   last_item;
    int                     addr;

    assign accept = start && !busy && (token < TOKEN_W'(VOCAB_SIZE)); // bad token dropped

    // final b_ih word reaching the mac
    assign last_item = busy && data_valid && (last_kind == rnn_mem_pkg::KIND_B_IH)
                       && (last_neuron == LAST_HID);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy    <= 1'b0;
            issuing <= 1'b0;
            phase   <= rnn_mem_pkg::KIND_EMBED;
            neuron  <= '0;
            operand <= '0;
            done    <= 1'b0;
            commit  <= 1'b0;
        end
        else
        begin
            done   <= last_item;
            commit <= last_item; // last hidden word is in by now
            if (accept)
            begin
                busy    <= 1'b1;
                issuing <= 1'b1;
                phase   <= rnn_mem_pkg::KIND_EMBED;
                neuron  <= '0;
                operand <= '0;
            end
            else if (issuing)
            begin
                case (phase)
                    rnn_mem_pkg::KIND_EMBED:
                    begin
                        if (operand == LAST_EMB)
                        begin
                            phase   <= rnn_mem_pkg::KIND_W_HH;
                            operand <= '0;
                        end
                        else
                            operand <= operand + 1'b1;
                    end
                    rnn_mem_pkg::KIND_W_HH:
                    begin
                        if (operand == LAST_HID)
                        begin
                            phase   <= rnn_mem_pkg::KIND_B_HH;
                            operand <= '0;
                        end
                        else
                            operand <= operand + 1'b1;
                    end
                    rnn_mem_pkg::KIND_B_HH:
                        phase <= rnn_mem_pkg::KIND_W_IH;
                    rnn_mem_pkg::KIND_W_IH:
                    begin
                        if (operand == LAST_EMB)
                        begin
                            phase   <= rnn_mem_pkg::KIND_B_IH;
                            operand <= '0;
                        end
                        else
                            operand <= operand + 1'b1;
                    end
                    rnn_mem_pkg::KIND_B_IH:
                    begin
                        if (neuron == LAST_HID)
                            issuing <= 1'b0; // all reads out, wait for return
                        else
                        begin
                            neuron <= neuron + 1'b1;
                            phase  <= rnn_mem_pkg::KIND_W_HH;
                        end
                    end
                    default:
                        issuing <= 1'b0;
                endcase
            end
            if (done)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            token_q <= token;
    end

    // address map
    always_comb
    begin
        case (phase)
            rnn_mem_pkg::KIND_EMBED: addr = int'(token_q) * EMBED_SIZE + int'(operand);
            rnn_mem_pkg::KIND_W_HH:  addr = W_HH_BASE + int'(neuron) * HIDDEN_SIZE + int'(operand);
            rnn_mem_pkg::KIND_B_HH:  addr = B_HH_BASE + int'(neuron);
            rnn_mem_pkg::KIND_W_IH:  addr = W_IH_BASE + int'(neuron) * EMBED_SIZE + int'(operand);
            rnn_mem_pkg::KIND_B_IH:  addr = B_IH_BASE + int'(neuron);
            default:                 addr = 0;
        endcase
    end

    assign rd_en      = issuing;
    assign rd_addr    = ADDR_W'(addr);
    assign rd_kind    = phase;
    assign rd_operand = operand;
    assign rd_neuron  = neuron;

endmodule

`default_nettype wire

// ==== src/weight_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_memory #(
    parameter int ADDR_W = 9
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         wr_en,
    input  wire [ADDR_W-1:0]            wr_addr,
    input  wire rnn_num_pkg::word_t     wr_data,
    input  wire                         rd_en,
    input  wire [ADDR_W-1:0]            rd_addr,
    input  wire rnn_mem_pkg::req_kind_t rd_kind,
    input  wire rnn_mem_pkg::idx_t      rd_operand,
    input  wire rnn_mem_pkg::idx_t      rd_neuron,
    output logic                        data_valid,
    output rnn_num_pkg::word_t          data,
    output rnn_mem_pkg::req_kind_t      data_kind,
    output rnn_mem_pkg::idx_t           data_operand,
    output rnn_mem_pkg::idx_t           data_neuron
);

    localparam int DEPTH = 2 ** ADDR_W;

    rnn_num_pkg::word_t     mem [DEPTH];
    logic                   s1_valid;
    rnn_num_pkg::word_t     s1_data;
    rnn_mem_pkg::req_kind_t s1_kind;
    rnn_mem_pkg::idx_t      s1_operand;
    rnn_mem_pkg::idx_t      s1_neuron;

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data; // load port, idle only
        s1_data      <= mem[rd_addr];
        s1_kind      <= rd_kind;     // tag rides with the word
        s1_operand   <= rd_operand;
        s1_neuron    <= rd_neuron;
        data         <= s1_data;
        data_kind    <= s1_kind;
        data_operand <= s1_operand;
        data_neuron  <= s1_neuron;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            s1_valid   <= 1'b0;
            data_valid <= 1'b0;
        end
        else
        begin
            s1_valid   <= rd_en;
            data_valid <= s1_valid; // two cycles after rd_en
        end
    end

endmodule

`default_nettype wire

// ==== src/neuron_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module neuron_mac #(
    parameter int EMBED_SIZE  = 4,
    parameter int HIDDEN_SIZE = 8
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         data_valid,
    input  wire rnn_num_pkg::word_t     data,
    input  wire rnn_mem_pkg::req_kind_t data_kind,
    input  wire rnn_mem_pkg::idx_t      data_operand,
    input  wire rnn_mem_pkg::idx_t      data_neuron,
    input  wire rnn_num_pkg::word_t     old_value,
    input  wire rnn_num_pkg::word_t     emb_value,
    output rnn_mem_pkg::idx_t           old_idx,
    output rnn_mem_pkg::idx_t           emb_idx_rd,
    output logic                        emb_we,
    output rnn_mem_pkg::idx_t           emb_idx,
    output rnn_num_pkg::word_t          emb_data,
    output logic                        hid_we,
    output rnn_mem_pkg::idx_t           hid_idx,
    output rnn_num_pkg::word_t          hid_data
);

    // tags carry operand and neuron numbers, they must fit
    if (EMBED_SIZE > 2 ** rnn_mem_pkg::OPERAND_IDX_W ||
        HIDDEN_SIZE > 2 ** rnn_mem_pkg::OPERAND_IDX_W)
    begin : g_size_check
        $error("operand index tag too narrow for the cell sizes");
    end

    rnn_num_pkg::acc_t acc_q;
    rnn_num_pkg::acc_t addend;
    rnn_num_pkg::acc_t sum;

    always_comb
    begin
        case (data_kind)
            rnn_mem_pkg::KIND_W_HH:
                addend = rnn_num_pkg::acc_t'(data) * rnn_num_pkg::acc_t'(old_value);
            rnn_mem_pkg::KIND_W_IH:
                addend = rnn_num_pkg::acc_t'(data) * rnn_num_pkg::acc_t'(emb_value);
            rnn_mem_pkg::KIND_B_HH, rnn_mem_pkg::KIND_B_IH:
                addend = rnn_num_pkg::acc_t'(data) <<< rnn_num_pkg::FRAC_BITS; // to q16.16
            default:
                addend = '0;
        endcase
        sum = acc_q + addend; // wraps mod 2^32
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            acc_q <= '0;
        else if (data_valid)
        begin
            case (data_kind)
                rnn_mem_pkg::KIND_W_HH, rnn_mem_pkg::KIND_B_HH, rnn_mem_pkg::KIND_W_IH:
                    acc_q <= sum;
                rnn_mem_pkg::KIND_B_IH:
                    acc_q <= '0; // neuron finished
                default:
                    acc_q <= acc_q;
            endcase
        end
    end

    // operand lookup follows the returning tag
    assign old_idx    = data_operand;
    assign emb_idx_rd = data_operand;

    assign emb_we   = data_valid && (data_kind == rnn_mem_pkg::KIND_EMBED);
    assign emb_idx  = data_operand;
    assign emb_data = data;

    assign hid_we   = data_valid && (data_kind == rnn_mem_pkg::KIND_B_IH);
    assign hid_idx  = data_neuron;
    assign hid_data = sum[rnn_num_pkg::FRAC_BITS +: rnn_num_pkg::WORD_W]; // back to q8.8

endmodule

`default_nettype wire

// ==== src/rnn_state_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module rnn_state_file #(
    parameter int EMBED_SIZE  = 4,
    parameter int HIDDEN_SIZE = 8
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     emb_we,
    input  wire rnn_mem_pkg::idx_t  emb_idx,
    input  wire rnn_num_pkg::word_t emb_data,
    input  wire                     hid_we,
    input  wire rnn_mem_pkg::idx_t  hid_idx,
    input  wire rnn_num_pkg::word_t hid_data,
    input  wire rnn_mem_pkg::idx_t  old_idx,
    input  wire rnn_mem_pkg::idx_t  emb_idx_rd,
    input  wire                     commit,
    input  wire rnn_mem_pkg::idx_t  hidden_sel,
    output rnn_num_pkg::word_t      old_value,
    output rnn_num_pkg::word_t      emb_value,
    output rnn_num_pkg::word_t      hidden_value
);

    // array index widths, at least one bit
    localparam int EMB_W = (EMBED_SIZE > 1) ? $clog2(EMBED_SIZE) : 1;
    localparam int HID_W = (HIDDEN_SIZE > 1) ? $clog2(HIDDEN_SIZE) : 1;

    rnn_num_pkg::word_t emb_q [EMBED_SIZE];
    rnn_num_pkg::word_t new_q [HIDDEN_SIZE];
    rnn_num_pkg::word_t old_q [HIDDEN_SIZE];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < EMBED_SIZE; i++)
                emb_q[i] <= '0;
            for (int i = 0; i < HIDDEN_SIZE; i++)
            begin
                new_q[i] <= '0;
                old_q[i] <= '0;
            end
        end
        else
        begin
            if (emb_we)
                emb_q[emb_idx[EMB_W-1:0]] <= emb_data;
            if (hid_we)
                new_q[hid_idx[HID_W-1:0]] <= hid_data;
            if (commit)
                old_q <= new_q; // new state becomes old for next step
        end
    end

    assign old_value    = old_q[old_idx[HID_W-1:0]];
    assign emb_value    = emb_q[emb_idx_rd[EMB_W-1:0]];
    assign hidden_value = old_q[hidden_sel[HID_W-1:0]]; // readout of committed state

endmodule

`default_nettype wire

// ==== src/rnn_cell_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rnn_cell_top #(
    parameter int VOCAB_SIZE  = 76,
    parameter int EMBED_SIZE  = 4,
    parameter int HIDDEN_SIZE = 8,
    localparam int MEM_DEPTH  = VOCAB_SIZE * EMBED_SIZE + HIDDEN_SIZE * EMBED_SIZE
                                + HIDDEN_SIZE * HIDDEN_SIZE + 2 * HIDDEN_SIZE,
    localparam int ADDR_W     = $clog2(MEM_DEPTH),
    localparam int TOKEN_W    = $clog2(VOCAB_SIZE) + 1
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     wr_en,
    input  wire [ADDR_W-1:0]        wr_addr,
    input  wire rnn_num_pkg::word_t wr_data,
    input  wire                     start,
    input  wire [TOKEN_W-1:0]       token,
    output logic                    busy,
    output logic                    done,
    input  wire rnn_mem_pkg::idx_t  hidden_sel,
    output rnn_num_pkg::word_t      hidden_value
);

    logic                   rd_en;
    logic [ADDR_W-1:0]      rd_addr;
    rnn_mem_pkg::req_kind_t rd_kind;
    rnn_mem_pkg::idx_t      rd_operand;
    rnn_mem_pkg::idx_t      rd_neuron;

    logic                   data_valid;
    rnn_num_pkg::word_t     data;
    rnn_mem_pkg::req_kind_t data_kind;
    rnn_mem_pkg::idx_t      data_operand;
    rnn_mem_pkg::idx_t      data_neuron;

    rnn_mem_pkg::idx_t      old_idx;
    rnn_mem_pkg::idx_t      emb_idx_rd;
    rnn_num_pkg::word_t     old_value;
    rnn_num_pkg::word_t     emb_value;
    logic                   emb_we;
    rnn_mem_pkg::idx_t      emb_idx;
    rnn_num_pkg::word_t     emb_data;
    logic                   hid_we;
    rnn_mem_pkg::idx_t      hid_idx;
    rnn_num_pkg::word_t     hid_data;
    logic                   commit;

    rnn_step_sequencer #(
        .VOCAB_SIZE  (VOCAB_SIZE),
        .EMBED_SIZE  (EMBED_SIZE),
        .HIDDEN_SIZE (HIDDEN_SIZE),
        .ADDR_W      (ADDR_W)
    ) u_seq (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .token       (token),
        .data_valid  (data_valid),
        .last_kind   (data_kind),   // watches the returning stream
        .last_neuron (data_neuron),
        .busy        (busy),
        .done        (done),
        .commit      (commit),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_kind     (rd_kind),
        .rd_operand  (rd_operand),
        .rd_neuron   (rd_neuron)
    );

    weight_memory #(
        .ADDR_W (ADDR_W)
    ) u_mem (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_kind      (rd_kind),
        .rd_operand   (rd_operand),
        .rd_neuron    (rd_neuron),
        .data_valid   (data_valid),
        .data         (data),
        .data_kind    (data_kind),
        .data_operand (data_operand),
        .data_neuron  (data_neuron)
    );

    neuron_mac #(
        .EMBED_SIZE  (EMBED_SIZE),
        .HIDDEN_SIZE (HIDDEN_SIZE)
    ) u_mac (
        .clk          (clk),
        .reset        (reset),
        .data_valid   (data_valid),
        .data         (data),
        .data_kind    (data_kind),
        .data_operand (data_operand),
        .data_neuron  (data_neuron),
        .old_value    (old_value),
        .emb_value    (emb_value),
        .old_idx      (old_idx),
        .emb_idx_rd   (emb_idx_rd),
        .emb_we       (emb_we),
        .emb_idx      (emb_idx),
        .emb_data     (emb_data),
        .hid_we       (hid_we),
        .hid_idx      (hid_idx),
        .hid_data     (hid_data)
    );

    rnn_state_file #(
        .EMBED_SIZE  (EMBED_SIZE),
        .HIDDEN_SIZE (HIDDEN_SIZE)
    ) u_state (
        .clk          (clk),
        .reset        (reset),
        .emb_we       (emb_we),
        .emb_idx      (emb_idx),
        .emb_data     (emb_data),
        .hid_we       (hid_we),
        .hid_idx      (hid_idx),
        .hid_data     (hid_data),
        .old_idx      (old_idx),
        .emb_idx_rd   (emb_idx_rd),
        .commit       (commit),
        .hidden_sel   (hidden_sel),
        .old_value    (old_value),
        .emb_value    (emb_value),
        .hidden_value (hidden_value)
    );

endmodule

`default_nettype wire

// ==== dv/rnn_cell_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module rnn_cell_asserts (
    input wire clk,
    input wire reset,
    input wire busy,
    input wire done,
    input wire wr_en
);

    a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done held high for more than one cycle");

    // step ends one cycle after done
    a_busy_falls: assert property (@(posedge clk) disable iff (reset) done |=> !busy)
        else $error("busy still high the cycle after done");

    a_no_load_busy: assert property (@(posedge clk) disable iff (reset) !(wr_en && busy))
        else $error("weight write during a step");

endmodule

bind rnn_cell_top rnn_cell_asserts rnn_cell_asserts_i (
    .clk   (clk),
    .reset (reset),
    .busy  (busy),
    .done  (done),
    .wr_en (wr_en)
);

`default_nettype wire

// ==== dv/rnn_cell_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rnn_cell_tb;

    localparam int VOCAB_SIZE   = 76;
    localparam int EMBED_SIZE   = 4;
    localparam int HIDDEN_SIZE  = 8;
    localparam int MEM_DEPTH    = VOCAB_SIZE * EMBED_SIZE + HIDDEN_SIZE * EMBED_SIZE
                                  + HIDDEN_SIZE * HIDDEN_SIZE + 2 * HIDDEN_SIZE;
    localparam int ADDR_W       = $clog2(MEM_DEPTH);
    localparam int TOKEN_W      = $clog2(VOCAB_SIZE) + 1;
    localparam int W_IH_BASE    = VOCAB_SIZE * EMBED_SIZE;
    localparam int W_HH_BASE    = W_IH_BASE + HIDDEN_SIZE * EMBED_SIZE;
    localparam int B_IH_BASE    = W_HH_BASE + HIDDEN_SIZE * HIDDEN_SIZE;
    localparam int B_HH_BASE    = B_IH_BASE + HIDDEN_SIZE;
    localparam int STEP_TIMEOUT = 300; // a step takes about 120 cycles
    localparam int QUIET_CYCLES = 150;
    localparam int NUM_ROWS     = 7;

    // token, accepted, reload weights first, extra start while busy
    int row_token  [NUM_ROWS] = '{5, 42, 17, 76, 200, 3, 75};
    bit row_accept [NUM_ROWS] = '{1, 1, 1, 0, 0, 1, 1};
    bit row_reload [NUM_ROWS] = '{0, 0, 0, 0, 0, 1, 0};
    bit row_extra  [NUM_ROWS] = '{0, 0, 1, 0, 0, 0, 0};

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   wr_en;
    logic [ADDR_W-1:0]      wr_addr;
    rnn_num_pkg::word_t     wr_data;
    logic                   start;
    logic [TOKEN_W-1:0]     token;
    logic                   busy;
    logic                   done;
    rnn_mem_pkg::idx_t      hidden_sel;
    rnn_num_pkg::word_t     hidden_value;

    rnn_num_pkg::word_t     ref_mem [MEM_DEPTH];   // mirror of the weight memory
    rnn_num_pkg::word_t     ref_old [HIDDEN_SIZE]; // committed hidden state
    rnn_num_pkg::word_t     expected [HIDDEN_SIZE];
    logic [31:0]            rng_state = 32'h184627a2;
    int                     errors = 0;
    int                     done_count = 0;

    rnn_cell_top #(
        .VOCAB_SIZE  (VOCAB_SIZE),
        .EMBED_SIZE  (EMBED_SIZE),
        .HIDDEN_SIZE (HIDDEN_SIZE)
    ) rnn_cell_top_i (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .start        (start),
        .token        (token),
        .busy         (busy),
        .done         (done),
        .hidden_sel   (hidden_sel),
        .hidden_value (hidden_value)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        if (done)
            done_count <= done_count + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic load_weights();
        rnn_num_pkg::word_t w;
        for (int a = 0; a < MEM_DEPTH; a++)
        begin
            rng_state = xorshift(rng_state);
            w = rnn_num_pkg::word_t'(int'(rng_state % 32'd1025) - 512); // within +-2.0
            @(negedge clk);
            wr_en   = 1'b1;
            wr_addr = ADDR_W'(a);
            wr_data = w;
            ref_mem[a] = w;
        end
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    // one recurrent step on the mirrored memory
    task automatic model_step(input int tok);
        rnn_num_pkg::word_t emb [EMBED_SIZE];
        int                 acc;
        logic [31:0]        bits;
        for (int j = 0; j < EMBED_SIZE; j++)
            emb[j] = ref_mem[tok * EMBED_SIZE + j];
        for (int n = 0; n < HIDDEN_SIZE; n++)
        begin
            acc = 0;
            for (int k = 0; k < HIDDEN_SIZE; k++)
                acc = acc + int'(ref_mem[W_HH_BASE + n * HIDDEN_SIZE + k]) * int'(ref_old[k]);
            acc = acc + int'(ref_mem[B_HH_BASE + n]) * 256; // bias up to q16.16
            for (int j = 0; j < EMBED_SIZE; j++)
                acc = acc + int'(ref_mem[W_IH_BASE + n * EMBED_SIZE + j]) * int'(emb[j]);
            acc = acc + int'(ref_mem[B_IH_BASE + n]) * 256;
            bits = acc;
            expected[n] = bits[23:8];
        end
    endtask

    task automatic pulse_start(input int tok);
        @(negedge clk);
        start = 1'b1;
        token = TOKEN_W'(tok);
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_for_done(output bit seen);
        seen = 1'b0;
        for (int c = 0; c < STEP_TIMEOUT && !seen; c++)
        begin
            @(negedge clk);
            if (done)
                seen = 1'b1;
        end
    endtask

    task automatic check_hidden();
        for (int i = 0; i < HIDDEN_SIZE; i++)
        begin
            @(negedge clk);
            hidden_sel = rnn_mem_pkg::idx_t'(i);
            #1; // combinational readout settles
            check_value($sformatf("hidden_value[%0d]", i), hidden_value, expected[i]);
        end
    endtask

    initial
    begin
        bit seen;
        int errors_before;
        int dones_before;
        int failed_tests;
        reset      = 1'b1;
        wr_en      = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        start      = 1'b0;
        token      = '0;
        hidden_sel = '0;
        failed_tests = 0;
        for (int i = 0; i < HIDDEN_SIZE; i++)
            ref_old[i] = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        expected = ref_old; // all zero out of reset
        check_hidden();
        if (errors != 0)
            failed_tests++;
        $display("test reset: %s", (errors == 0) ? "ok" : "FAILED");
        load_weights();

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            errors_before = errors;
            if (row_reload[r])
                load_weights();
            if (row_accept[r])
                model_step(row_token[r]);
            else
                expected = ref_old; // rejected token leaves state alone
            dones_before = done_count;
            pulse_start(row_token[r]);
            if (row_extra[r])
            begin
                check_value("busy", 16'(busy), 16'd1);
                pulse_start(60); // must be ignored
            end
            wait_for_done(seen);
            if (seen != row_accept[r])
            begin
                errors++;
                if (row_accept[r])
                    $display("done did not arrive within %0d cycles", STEP_TIMEOUT);
                else
                    $display("done arrived for token %0d, which is out of range",
                             row_token[r]);
            end
            repeat (QUIET_CYCLES) @(negedge clk);
            check_value("done_count", 16'(done_count - dones_before), 16'(row_accept[r]));
            check_value("busy", 16'(busy), 16'd0);
            check_hidden();
            ref_old = expected;
            if (errors != errors_before)
                failed_tests++;
            $display("test %0d token %0d: %s", r, row_token[r],
                     (errors == errors_before) ? "ok" : "FAILED");
        end

        $display("%0d tests run, %0d failed, %0d errors", NUM_ROWS + 1, failed_tests, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rnn_cell.f ====
src/rnn_num_pkg.sv
src/rnn_mem_pkg.sv
src/rnn_step_sequencer.sv
src/weight_memory.sv
src/neuron_mac.sv
src/rnn_state_file.sv
src/rnn_cell_top.sv
dv/rnn_cell_asserts.sv
dv/rnn_cell_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rnn cell testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rnn_cell_tb -f rnn_cell.f -o rnn_cell_sim

# show the run and fail unless the pass line appears
./obj_dir/rnn_cell_sim | tee /dev/stderr | grep -x "Test passed" > /dev/null
echo "simulation passed"
